/* design/ep_mem_defs.svh */
`ifndef EP_MEM_DEFS_SVH
`define EP_MEM_DEFS_SVH

// ----------------------------------------------------------------------------
// Aperture geometry
// ----------------------------------------------------------------------------
`define EP_MEM_ADDR_W   7       // Word index width
`define EP_MEM_DATA_W   32      // Bus and storage word width
`define EP_MEM_BYTES    4       // Byte lanes per word
`define EP_MEM_DEPTH    128     // Words in the array
`define EP_MEM_PADDR_W  12      // APB byte address width

`endif

/* design/ep_mem_pkg.sv */
`default_nettype none

package ep_mem_pkg;

`include "ep_mem_defs.svh"

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------
    typedef logic [`EP_MEM_DATA_W-1:0]  word_t;       // One data word
    typedef logic [`EP_MEM_ADDR_W-1:0]  mem_addr_t;   // Word index into array
    typedef logic [`EP_MEM_BYTES-1:0]   strb_t;       // Bit i covers storage byte i
    typedef logic [`EP_MEM_PADDR_W-1:0] paddr_t;      // APB byte address

    // Write controller sequence
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_READ,
        WR_MERGE
    } wr_state_e;

    // ------------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic   psel;
        logic   penable;
        logic   pwrite;
        paddr_t paddr;
        word_t  pwdata;                                // Bus byte order
        strb_t  pstrb;
    } apb_req_t;

    typedef struct packed {
        word_t  prdata;                                // Bus byte order
        logic   pready;
        logic   pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic   start;                                 // One-cycle pulse
        word_t  data;                                  // Storage byte order
        strb_t  strb;
    } wr_cmd_t;

    typedef struct packed {
        logic   we;
        word_t  wdata;
    } mem_wr_t;

endpackage

`default_nettype wire

/* design/ep_mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ep_mem_defs.svh"

// Word-addressed storage, little-endian within each word
module ep_mem_array
    import ep_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire mem_addr_t addr_i,
    output      word_t     rdata_o,
    input  wire mem_wr_t   mem_wr_i
);

    word_t mem [0:`EP_MEM_DEPTH-1];

    // ------------------------------------------------------------------------
    // Synchronous write, registered read at one shared address
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mem_wr_i.we) begin
            mem[addr_i] <= mem_wr_i.wdata;                 // Commits on this edge
        end
    end

    // Old contents are returned when a read and a write share an edge
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];                            // One cycle latency
    end

endmodule

`default_nettype wire

/* design/ep_mem_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ep_mem_defs.svh"

// Read-modify-write sequencer for strobed writes
module ep_mem_wr_ctrl
    import ep_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire wr_cmd_t wr_cmd_i,
    input  wire word_t   mem_rdata_i,
    output      mem_wr_t mem_wr_o,
    output      logic    wr_done_o
);

    wr_state_e state_q;
    wr_state_e state_d;
    word_t     new_q;                                      // Incoming word, storage order
    strb_t     strb_q;
    word_t     old_q;                                      // Word read back from array
    word_t     merged;
    word_t     wdata_q;
    logic      we_q;

    // ------------------------------------------------------------------------
    // Sequence control
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (wr_cmd_i.start) begin
                    state_d = WR_READ;
                end
            end
            WR_READ:  state_d = WR_MERGE;                  // Old word valid this cycle
            WR_MERGE: state_d = WR_IDLE;
            default:  state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= WR_IDLE;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            we_q    <= (state_q == WR_MERGE);              // High for one cycle
        end
    end

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------

    // Per byte, strobe picks the new byte over the stored one
    always_comb begin
        for (int i = 0; i < `EP_MEM_BYTES; i++) begin
            merged[8*i +: 8] = strb_q[i] ? new_q[8*i +: 8] : old_q[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == WR_IDLE && wr_cmd_i.start) begin
            new_q  <= wr_cmd_i.data;
            strb_q <= wr_cmd_i.strb;
        end
        if (state_q == WR_READ) begin
            old_q <= mem_rdata_i;                          // Capture old word
        end
        if (state_q == WR_MERGE) begin
            wdata_q <= merged;
        end
    end

    assign mem_wr_o.we    = we_q;
    assign mem_wr_o.wdata = wdata_q;
    assign wr_done_o      = we_q;                          // Same cycle as the commit

endmodule

`default_nettype wire

/* design/ep_mem_apb_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ep_mem_defs.svh"

// APB slave front end for the memory aperture
module ep_mem_apb_port
    import ep_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire apb_req_t  apb_req_i,
    output      apb_rsp_t  apb_rsp_o,
    output      mem_addr_t mem_addr_o,
    input  wire word_t     mem_rdata_i,
    output      wr_cmd_t   wr_cmd_o,
    input  wire logic      wr_done_i
);

    logic  access;                                         // Any access-phase cycle
    logic  aligned;
    logic  first;                                          // First access cycle, A0
    logic  started_q;
    logic  rd_ready;
    logic  ready;
    word_t wdata_st;                                       // PWDATA in storage order
    word_t rdata_bus;                                      // Array word in bus order

    // ------------------------------------------------------------------------
    // Byte-lane reordering
    // ------------------------------------------------------------------------

    // Bus order puts the lowest-address byte on top, storage order at the
    // bottom, so the same lane reversal works in both directions.
    function automatic word_t swap_bytes(input word_t w);
        word_t r;
        for (int i = 0; i < `EP_MEM_BYTES; i++) begin
            r[8*i +: 8] = w[`EP_MEM_DATA_W-8-8*i +: 8];
        end
        return r;
    endfunction

    assign wdata_st  = swap_bytes(apb_req_i.pwdata);
    assign rdata_bus = swap_bytes(mem_rdata_i);

    // ------------------------------------------------------------------------
    // Phase decode
    // ------------------------------------------------------------------------
    assign access  = apb_req_i.psel & apb_req_i.penable;
    assign aligned = (apb_req_i.paddr[1:0] == 2'b00);
    assign first   = access & ~started_q;

    // Set in A0 of an aligned transfer, cleared on completion
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started_q <= 1'b0;
        end else if (ready) begin
            started_q <= 1'b0;
        end else if (first && aligned) begin
            started_q <= 1'b1;
        end
    end

    // Word index is taken straight from the held address
    assign mem_addr_o = apb_req_i.paddr[`EP_MEM_ADDR_W+1:2];

    // ------------------------------------------------------------------------
    // Write command
    // ------------------------------------------------------------------------
    assign wr_cmd_o.start = first & aligned & apb_req_i.pwrite;   // Once per write
    assign wr_cmd_o.data  = wdata_st;
    assign wr_cmd_o.strb  = apb_req_i.pstrb;

    // ------------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------------

    // Array data sampled at the end of A0 is valid in A1
    assign rd_ready = ~apb_req_i.pwrite & started_q;

    always_comb begin
        if (!access) begin
            ready = 1'b0;
        end else if (!aligned) begin
            ready = 1'b1;                                  // Error completes in A0
        end else if (apb_req_i.pwrite) begin
            ready = wr_done_i;
        end else begin
            ready = rd_ready;
        end
    end

    assign apb_rsp_o.pready  = ready;
    assign apb_rsp_o.pslverr = access & ~aligned;
    assign apb_rsp_o.prdata  = rdata_bus;

endmodule

`default_nettype wire

/* design/ep_mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

// Endpoint memory aperture behind an APB slave port
module ep_mem_access
    import ep_mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire apb_req_t apb_req_i,
    output      apb_rsp_t apb_rsp_o
);

    mem_addr_t mem_addr;                                   // Shared by reads and RMW
    word_t     mem_rdata;
    wr_cmd_t   wr_cmd;
    mem_wr_t   mem_wr;
    logic      wr_done;

    // ------------------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------------------
    ep_mem_apb_port u_apb_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .mem_addr_o  (mem_addr),
        .mem_rdata_i (mem_rdata),
        .wr_cmd_o    (wr_cmd),
        .wr_done_i   (wr_done)
    );

    ep_mem_wr_ctrl u_wr_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_cmd_i    (wr_cmd),
        .mem_rdata_i (mem_rdata),
        .mem_wr_o    (mem_wr),
        .wr_done_o   (wr_done)
    );

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    ep_mem_array u_array (
        .clk      (clk),
        .addr_i   (mem_addr),
        .rdata_o  (mem_rdata),
        .mem_wr_i (mem_wr)
    );

endmodule

`default_nettype wire

/* tests/ep_mem_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

// APB protocol properties on the slave port
module ep_mem_asserts
    import ep_mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire apb_req_t apb_req_i,
    input  wire apb_rsp_t apb_rsp_i
);

    int   fail_count = 0;                                  // Read by the testbench
    logic access;

    assign access = apb_req_i.psel & apb_req_i.penable;

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        access && !apb_rsp_i.pready |=> $stable(apb_req_i))
        else begin
            $error("APB request changed before pready");
            fail_count++;
        end

    err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp_i.pslverr |-> access && apb_rsp_i.pready)
        else begin
            $error("pslverr raised outside a completing access cycle");
            fail_count++;
        end

    // Setup, then A0 of an aligned write; pready lands in A3
    write_len: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req_i.psel && !apb_req_i.penable) ##1
        (access && apb_req_i.pwrite && apb_req_i.paddr[1:0] == 2'b00)
        |-> !apb_rsp_i.pready [*3] ##1 apb_rsp_i.pready)
        else begin
            $error("write access phase did not last 4 cycles");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tests/ep_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ep_mem_defs.svh"

// Watches the APB port and compares every completed transfer
module ep_mem_checker
    import ep_mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire apb_req_t apb_req_i,
    input  wire apb_rsp_t apb_rsp_i,
    output      int       errors_o,
    output      int       checks_o
);

    word_t shadow [0:`EP_MEM_DEPTH-1];                     // Storage order
    strb_t known  [0:`EP_MEM_DEPTH-1];                     // Bytes written so far
    int    cycles;                                         // Access cycles seen

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Bus byte b sits at the top end, storage byte b at the bottom end
    function automatic word_t store_ref(input word_t old_st, input word_t bus_w,
                                        input strb_t strb);
        word_t res;
        res = old_st;
        for (int b = 0; b < `EP_MEM_BYTES; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = bus_w[`EP_MEM_DATA_W-1-8*b -: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t bus_order(input word_t st);
        word_t res;
        for (int b = 0; b < `EP_MEM_BYTES; b++) begin
            res[`EP_MEM_DATA_W-1-8*b -: 8] = st[8*b +: 8];
        end
        return res;
    endfunction

    task automatic compare_value(input string name, input word_t exp, input word_t act);
        checks_o++;
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            errors_o++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Comparison
    // ------------------------------------------------------------------------
    task automatic check_transfer();
        mem_addr_t idx;
        logic      aligned;
        word_t     mask;
        idx     = apb_req_i.paddr[`EP_MEM_ADDR_W+1:2];
        aligned = (apb_req_i.paddr[1:0] == 2'b00);
        compare_value("pslverr", word_t'(!aligned), word_t'(apb_rsp_i.pslverr));
        compare_value("pready latency", !aligned ? 1 : (apb_req_i.pwrite ? 4 : 2), cycles);
        if (aligned && apb_req_i.pwrite) begin
            shadow[idx] = store_ref(shadow[idx], apb_req_i.pwdata, apb_req_i.pstrb);
            known[idx]  = known[idx] | apb_req_i.pstrb;
        end else if (aligned && known[idx] != '0) begin
            mask = bus_order(store_ref('0, '1, known[idx]));   // Known bytes only
            compare_value("prdata", bus_order(shadow[idx]) & mask, apb_rsp_i.prdata & mask);
        end
    endtask

    initial begin
        errors_o = 0;
        checks_o = 0;
        cycles   = 0;
        foreach (known[i]) begin
            known[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (rst_n && apb_req_i.psel && apb_req_i.penable) begin
            cycles = cycles + 1;
            if (apb_rsp_i.pready) begin
                check_transfer();
                cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_ep_mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ep_mem_access
    import ep_mem_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 200;
    localparam int N_XFERS      = 25 + N_RANDOM;           // Directed plus random
    localparam strb_t PART_STRB [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110, 4'b0000};

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       errors;
    int       checks;
    paddr_t   addr;

    ep_mem_access dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    ep_mem_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_i (apb_rsp),
        .errors_o  (errors),
        .checks_o  (checks)
    );

    bind ep_mem_apb_port ep_mem_asserts asserts_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req_i),
        .apb_rsp_i (apb_rsp_o)
    );

    // ------------------------------------------------------------------------
    // Clock and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #((N_XFERS * 6 + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("Timeout: a transfer did not complete in time");
        $display("Test FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // APB master
    // ------------------------------------------------------------------------
    task automatic bus_transfer(input logic is_write, input paddr_t a, input word_t d,
                                input strb_t s);
        @(negedge clk);
        apb_req.psel    = 1'b1;                            // Setup cycle
        apb_req.penable = 1'b0;
        apb_req.pwrite  = is_write;
        apb_req.paddr   = a;
        apb_req.pwdata  = d;
        apb_req.pstrb   = s;
        @(negedge clk);
        apb_req.penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!apb_rsp.pready);
    endtask

    task automatic write_word(input paddr_t a, input word_t d, input strb_t s);
        bus_transfer(1'b1, a, d, s);
    endtask

    task automatic read_word(input paddr_t a);
        bus_transfer(1'b0, a, '0, '0);
    endtask

    initial begin
        apb_req = '0;
        rst_n   = 1'b0;
        void'($urandom(85));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 4; i++) begin
            write_word(paddr_t'(4 * i), $urandom(), 4'hF);  // Full strobe, then read back
            read_word(paddr_t'(4 * i));
        end

        write_word(12'h040, 32'h1122_3344, 4'hF);           // Known word for partial writes
        foreach (PART_STRB[i]) begin
            write_word(12'h040, 32'hA0B0_C0D0 + i, PART_STRB[i]);
            read_word(12'h040);
        end

        write_word(12'h080, 32'h5566_7788, 4'hF);
        write_word(12'h081, 32'hDEAD_BEEF, 4'hF);           // Unaligned address must not land
        read_word(12'h082);
        read_word(12'h080);

        for (int n = 0; n < N_RANDOM; n++) begin
            addr = paddr_t'($urandom_range(31, 0) * 4);     // Low words for more hits
            if ($urandom_range(1, 0) == 1) begin
                write_word(addr, $urandom(), strb_t'($urandom_range(15, 0)));
            end else begin
                read_word(addr);
            end
        end

        @(negedge clk);
        apb_req = '0;
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut_i.u_apb_port.asserts_i.fail_count);
        if (errors == 0 && dut_i.u_apb_port.asserts_i.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/ep_mem_pkg.sv
design/ep_mem_array.sv
design/ep_mem_wr_ctrl.sv
design/ep_mem_apb_port.sv
design/ep_mem_access.sv
tests/ep_mem_asserts.sv
tests/ep_mem_checker.sv
tests/tb_ep_mem_access.sv
